// File: dsp_params.svh
`ifndef DSP_PARAMS_SVH
`define DSP_PARAMS_SVH

// Datapath widths
`define DSP_DATA_W 32 // Host and unit word
`define DSP_ADDR_W 16 // Host byte address
`define DSP_RAM_AW 10 // 1024 words, bytes 0x0000 to 0x0FFF
`define DSP_STRB_W 4 // One strobe per byte lane

// External interrupt lines, active low at the pins
`define DSP_IRQ_N 2

// Serial divider, one quotient bit per step
`define DSP_DIV_STEPS 32

// Register block above the RAM window
`define DSP_FLAGS_ADDR 16'h1000 // Mask, clear, latches, busy
`define DSP_DIVIDEND_ADDR 16'h1004 // Read and write
`define DSP_DIVISOR_ADDR 16'h1008 // Write only, starts a division
`define DSP_QUOTIENT_ADDR 16'h100C // Read only
`define DSP_REMAINDER_ADDR 16'h1010 // Read only

`endif

// File: dsp_pkg.sv
`include "dsp_params.svh"

package dsp_pkg;

	// Flags word as the host writes it
	typedef struct packed
	{
		logic [`DSP_DATA_W-2*`DSP_IRQ_N-1:0] rsvd; // Ignored on write
		logic [`DSP_IRQ_N-1:0] irq_clear; // 1 clears the matching latch
		logic [`DSP_IRQ_N-1:0] irq_mask; // 1 lets the latch reach cpu_int
	} dsp_flags_wr_t;

	// Same word as the host reads it back
	typedef struct packed
	{
		logic [`DSP_DATA_W-2*`DSP_IRQ_N-2:0] rsvd; // Reads zero
		logic div_busy; // Divider still iterating
		logic [`DSP_IRQ_N-1:0] irq_latch; // Edge seen since last clear
		logic [`DSP_IRQ_N-1:0] irq_mask;
	} dsp_flags_rd_t;

	// One bus word, decoded per direction
	typedef union packed
	{
		logic [`DSP_DATA_W-1:0] raw;
		dsp_flags_wr_t wr;
		dsp_flags_rd_t rd;
	} dsp_flags_u;

endpackage

// File: dsp_host_slave.sv
`timescale 1ns/10ps
`include "dsp_params.svh"

module dsp_host_slave
(
	input logic sys_clk,
	input logic rst,
	input logic [`DSP_ADDR_W-1:0] s_axi_awaddr,
	input logic s_axi_awvalid,
	output logic s_axi_awready,
	input logic [`DSP_DATA_W-1:0] s_axi_wdata,
	input logic [`DSP_STRB_W-1:0] s_axi_wstrb,
	input logic s_axi_wvalid,
	output logic s_axi_wready,
	output logic [1:0] s_axi_bresp,
	output logic s_axi_bvalid,
	input logic s_axi_bready,
	input logic [`DSP_ADDR_W-1:0] s_axi_araddr,
	input logic s_axi_arvalid,
	output logic s_axi_arready,
	output logic [`DSP_DATA_W-1:0] s_axi_rdata,
	output logic [1:0] s_axi_rresp,
	output logic s_axi_rvalid,
	input logic s_axi_rready,
	output logic ram_we,
	output logic [`DSP_RAM_AW-1:0] ram_addr,
	output logic [`DSP_STRB_W-1:0] ram_wstrb,
	output logic [`DSP_DATA_W-1:0] ram_wdata,
	input logic [`DSP_DATA_W-1:0] ram_rdata,
	output logic dividend_wr,
	output logic divisor_wr,
	output logic [`DSP_DATA_W-1:0] wdata,
	input logic div_busy,
	input logic [`DSP_DATA_W-1:0] dividend,
	input logic [`DSP_DATA_W-1:0] quotient,
	input logic [`DSP_DATA_W-1:0] remainder,
	output logic flags_wr,
	output dsp_pkg::dsp_flags_u flags_wdata,
	input dsp_pkg::dsp_flags_u flags_rd
);

// One-hot unit select bits
localparam int sel_ram = 0;
localparam int sel_flags = 1;
localparam int sel_dividend = 2;
localparam int sel_divisor = 3;
localparam int sel_quot = 4;
localparam int sel_rem = 5;
localparam int sel_n = 6;

localparam logic [sel_n-1:0] wr_map = 6'b001111; // RAM, flags, dividend, divisor
localparam logic [sel_n-1:0] rd_map = 6'b110111; // Divisor is write only
localparam logic [1:0] resp_okay = 2'b00;
localparam logic [1:0] resp_slverr = 2'b10;

function automatic logic [sel_n-1:0] addr_dec(input logic [`DSP_ADDR_W-1:0] addr);
	logic [sel_n-1:0] sel;
	sel = '0;
	sel[sel_ram] = (addr[`DSP_ADDR_W-1:`DSP_RAM_AW+2] == '0); // Any byte of the window
	sel[sel_flags] = (addr == `DSP_FLAGS_ADDR);
	sel[sel_dividend] = (addr == `DSP_DIVIDEND_ADDR);
	sel[sel_divisor] = (addr == `DSP_DIVISOR_ADDR);
	sel[sel_quot] = (addr == `DSP_QUOTIENT_ADDR);
	sel[sel_rem] = (addr == `DSP_REMAINDER_ADDR);
	return sel;
endfunction

logic [sel_n-1:0] wr_dec;
logic [sel_n-1:0] ar_dec;
logic [sel_n-1:0] rd_sel; // Source of the pending read
logic aw_set;
logic ar_set;
logic wr_accept;
logic rd_accept;
logic rd_hold_off; // Result read arrives while divider runs
logic rd_wait;
logic rd_first; // First rvalid cycle, data taken live
logic [`DSP_DATA_W-1:0] rd_merge;
logic [`DSP_DATA_W-1:0] rdata_hold;

assign wr_dec = addr_dec(s_axi_awaddr);
assign ar_dec = addr_dec(s_axi_araddr) & rd_map;
assign wr_accept = s_axi_awready & s_axi_awvalid & s_axi_wvalid;
assign rd_accept = s_axi_arready & s_axi_arvalid;

// Ready pulses; write wins when both would rise together
assign aw_set = s_axi_awvalid & s_axi_wvalid & ~s_axi_awready & ~s_axi_bvalid;
assign ar_set = s_axi_arvalid & ~s_axi_arready & ~rd_wait & ~s_axi_rvalid & ~aw_set;
assign rd_hold_off = div_busy & (ar_dec[sel_quot] | ar_dec[sel_rem]);

// Unit strobes on the accept cycle
assign ram_we = wr_accept & wr_dec[sel_ram];
assign ram_addr = wr_accept ? s_axi_awaddr[`DSP_RAM_AW+1:2] : s_axi_araddr[`DSP_RAM_AW+1:2];
assign ram_wstrb = s_axi_wstrb;
assign ram_wdata = s_axi_wdata;
assign dividend_wr = wr_accept & wr_dec[sel_dividend];
assign divisor_wr = wr_accept & wr_dec[sel_divisor];
assign wdata = s_axi_wdata;
assign flags_wr = wr_accept & wr_dec[sel_flags];
assign flags_wdata.raw = s_axi_wdata;

// Read merge, OR of the gated sources
assign rd_merge = ({`DSP_DATA_W{rd_sel[sel_ram]}} & ram_rdata)
	| ({`DSP_DATA_W{rd_sel[sel_flags]}} & flags_rd.raw)
	| ({`DSP_DATA_W{rd_sel[sel_dividend]}} & dividend)
	| ({`DSP_DATA_W{rd_sel[sel_quot]}} & quotient)
	| ({`DSP_DATA_W{rd_sel[sel_rem]}} & remainder); // Unmapped gives zero

assign s_axi_rdata = rd_first ? rd_merge : rdata_hold; // Held after first cycle

always_ff @(posedge sys_clk)
begin
	if (rst)
	begin
		s_axi_awready <= 1'b0;
		s_axi_wready <= 1'b0;
		s_axi_bvalid <= 1'b0;
	end
	else
	begin
		s_axi_awready <= aw_set;
		s_axi_wready <= aw_set; // Always paired with awready
		if (wr_accept)
			s_axi_bvalid <= 1'b1;
		else if (s_axi_bready)
			s_axi_bvalid <= 1'b0;
	end
end

always_ff @(posedge sys_clk)
begin
	if (rst)
	begin
		s_axi_arready <= 1'b0;
		s_axi_rvalid <= 1'b0;
		rd_wait <= 1'b0;
		rd_first <= 1'b0;
	end
	else
	begin
		s_axi_arready <= ar_set;
		rd_first <= 1'b0;
		if (rd_accept)
		begin
			if (rd_hold_off)
				rd_wait <= 1'b1; // Park until busy falls
			else
			begin
				s_axi_rvalid <= 1'b1;
				rd_first <= 1'b1;
			end
		end
		else if (rd_wait && !div_busy)
		begin
			rd_wait <= 1'b0;
			s_axi_rvalid <= 1'b1;
			rd_first <= 1'b1;
		end
		else if (s_axi_rvalid && s_axi_rready)
			s_axi_rvalid <= 1'b0;
	end
end

// Response payloads
always_ff @(posedge sys_clk)
begin
	if (wr_accept)
		s_axi_bresp <= (|(wr_dec & wr_map)) ? resp_okay : resp_slverr;
	if (rd_accept)
	begin
		rd_sel <= ar_dec;
		s_axi_rresp <= (|ar_dec) ? resp_okay : resp_slverr;
	end
	if (rd_first)
		rdata_hold <= rd_merge; // Freeze against later unit writes
end

endmodule

// File: dsp_local_ram.sv
`timescale 1ns/10ps
`include "dsp_params.svh"

module dsp_local_ram
(
	input logic sys_clk,
	input logic ram_we,
	input logic [`DSP_RAM_AW-1:0] ram_addr,
	input logic [`DSP_STRB_W-1:0] ram_wstrb,
	input logic [`DSP_DATA_W-1:0] ram_wdata,
	output logic [`DSP_DATA_W-1:0] ram_rdata
);

localparam int depth = 1 << `DSP_RAM_AW; // 1024 words
localparam int lane_w = `DSP_DATA_W / `DSP_STRB_W; // 8 bits per lane

logic [`DSP_DATA_W-1:0] mem [0:depth-1];

// Byte lanes written independently
always_ff @(posedge sys_clk)
begin
	for (int b = 0; b < `DSP_STRB_W; b++)
	begin
		if (ram_we && ram_wstrb[b])
			mem[ram_addr][b*lane_w +: lane_w] <= ram_wdata[b*lane_w +: lane_w];
	end
end

// Registered read, old data on a same-cycle write
always_ff @(posedge sys_clk)
begin
	ram_rdata <= mem[ram_addr];
end

endmodule

// File: dsp_divider.sv
`timescale 1ns/10ps
`include "dsp_params.svh"

module dsp_divider
(
	input logic sys_clk,
	input logic rst,
	input logic dividend_wr,
	input logic divisor_wr,
	input logic [`DSP_DATA_W-1:0] wdata,
	output logic div_busy,
	output logic [`DSP_DATA_W-1:0] dividend,
	output logic [`DSP_DATA_W-1:0] quotient,
	output logic [`DSP_DATA_W-1:0] remainder
);

localparam int cnt_w = $clog2(`DSP_DIV_STEPS);
localparam logic [cnt_w-1:0] last_step = cnt_w'(`DSP_DIV_STEPS - 1);

logic [`DSP_DATA_W-1:0] divisor_q;
logic [cnt_w-1:0] step_cnt;
logic [`DSP_DATA_W:0] partial; // Remainder with next dividend bit
logic [`DSP_DATA_W:0] diff;
logic step_ok; // Divisor fits, quotient bit is one

// Quotient register starts as the dividend and shifts out its top bit
assign partial = {remainder, quotient[`DSP_DATA_W-1]};
assign diff = partial - {1'b0, divisor_q};
assign step_ok = (partial >= {1'b0, divisor_q}); // Always true for divisor zero

always_ff @(posedge sys_clk)
begin
	if (rst)
	begin
		dividend <= '0;
		divisor_q <= '0;
		quotient <= '0;
		remainder <= '0;
		step_cnt <= '0;
		div_busy <= 1'b0;
	end
	else
	begin
		if (dividend_wr)
			dividend <= wdata; // Used at the next divisor write
		if (divisor_wr)
		begin
			divisor_q <= wdata;
			quotient <= dividend;
			remainder <= '0;
			step_cnt <= '0;
			div_busy <= 1'b1; // Also restarts a running division
		end
		else if (div_busy)
		begin
			quotient <= {quotient[`DSP_DATA_W-2:0], step_ok};
			remainder <= step_ok ? diff[`DSP_DATA_W-1:0] : partial[`DSP_DATA_W-1:0];
			step_cnt <= step_cnt + 1'b1;
			if (step_cnt == last_step)
				div_busy <= 1'b0; // Results valid from here
		end
	end
end

endmodule

// File: dsp_irq_flags.sv
`timescale 1ns/10ps
`include "dsp_params.svh"

module dsp_irq_flags
(
	input logic sys_clk,
	input logic rst,
	input logic [`DSP_IRQ_N-1:0] ext_int_n,
	input logic flags_wr,
	input dsp_pkg::dsp_flags_u flags_wdata,
	input logic div_busy,
	output dsp_pkg::dsp_flags_u flags_rd,
	output logic cpu_int
);

import dsp_pkg::*;

logic [`DSP_IRQ_N-1:0] sync1_n; // First synchronizer stage
logic [`DSP_IRQ_N-1:0] sync2_n; // Second stage, safe to use
logic [`DSP_IRQ_N-1:0] prev_n; // Level one cycle back
logic [`DSP_IRQ_N-1:0] irq_edge;
logic [`DSP_IRQ_N-1:0] irq_clr;
logic [`DSP_IRQ_N-1:0] irq_mask;
logic [`DSP_IRQ_N-1:0] irq_latch;
dsp_flags_wr_t wr_view;
dsp_flags_rd_t rd_view;

// Idle level is high, so reset to ones avoids a false edge
always_ff @(posedge sys_clk)
begin
	if (rst)
	begin
		sync1_n <= '1;
		sync2_n <= '1;
		prev_n <= '1;
	end
	else
	begin
		sync1_n <= ext_int_n;
		sync2_n <= sync1_n;
		prev_n <= sync2_n;
	end
end

assign irq_edge = ~sync2_n & prev_n; // Falling edge, one cycle wide

// Host write side
assign wr_view = flags_wdata.wr;
assign irq_clr = flags_wr ? wr_view.irq_clear : '0;

always_ff @(posedge sys_clk)
begin
	if (rst)
	begin
		irq_mask <= '0;
		irq_latch <= '0;
		cpu_int <= 1'b0;
	end
	else
	begin
		if (flags_wr)
			irq_mask <= wr_view.irq_mask;
		irq_latch <= (irq_latch & ~irq_clr) | irq_edge; // New edge beats clear
		cpu_int <= |(irq_latch & irq_mask);
	end
end

// Host read side
always_comb
begin
	rd_view = '0;
	rd_view.irq_mask = irq_mask;
	rd_view.irq_latch = irq_latch;
	rd_view.div_busy = div_busy;
end

assign flags_rd.rd = rd_view;

endmodule

// File: dsp_top.sv
`timescale 1ns/10ps
`include "dsp_params.svh"

module dsp_top
(
	input logic sys_clk,
	input logic rst,
	input logic [`DSP_IRQ_N-1:0] ext_int_n,
	input logic [`DSP_ADDR_W-1:0] s_axi_awaddr,
	input logic s_axi_awvalid,
	output logic s_axi_awready,
	input logic [`DSP_DATA_W-1:0] s_axi_wdata,
	input logic [`DSP_STRB_W-1:0] s_axi_wstrb,
	input logic s_axi_wvalid,
	output logic s_axi_wready,
	output logic [1:0] s_axi_bresp,
	output logic s_axi_bvalid,
	input logic s_axi_bready,
	input logic [`DSP_ADDR_W-1:0] s_axi_araddr,
	input logic s_axi_arvalid,
	output logic s_axi_arready,
	output logic [`DSP_DATA_W-1:0] s_axi_rdata,
	output logic [1:0] s_axi_rresp,
	output logic s_axi_rvalid,
	input logic s_axi_rready,
	output logic cpu_int
);

import dsp_pkg::*;

// RAM port
logic ram_we;
logic [`DSP_RAM_AW-1:0] ram_addr;
logic [`DSP_STRB_W-1:0] ram_wstrb;
logic [`DSP_DATA_W-1:0] ram_wdata;
logic [`DSP_DATA_W-1:0] ram_rdata;

// Divider port
logic dividend_wr;
logic divisor_wr;
logic [`DSP_DATA_W-1:0] wdata;
logic div_busy;
logic [`DSP_DATA_W-1:0] dividend;
logic [`DSP_DATA_W-1:0] quotient;
logic [`DSP_DATA_W-1:0] remainder;

// Flags port
logic flags_wr;
dsp_flags_u flags_wdata;
dsp_flags_u flags_rd;

dsp_host_slave dsp_host_slave_i
(
	.sys_clk (sys_clk),
	.rst (rst),
	.s_axi_awaddr (s_axi_awaddr),
	.s_axi_awvalid (s_axi_awvalid),
	.s_axi_awready (s_axi_awready),
	.s_axi_wdata (s_axi_wdata),
	.s_axi_wstrb (s_axi_wstrb),
	.s_axi_wvalid (s_axi_wvalid),
	.s_axi_wready (s_axi_wready),
	.s_axi_bresp (s_axi_bresp),
	.s_axi_bvalid (s_axi_bvalid),
	.s_axi_bready (s_axi_bready),
	.s_axi_araddr (s_axi_araddr),
	.s_axi_arvalid (s_axi_arvalid),
	.s_axi_arready (s_axi_arready),
	.s_axi_rdata (s_axi_rdata),
	.s_axi_rresp (s_axi_rresp),
	.s_axi_rvalid (s_axi_rvalid),
	.s_axi_rready (s_axi_rready),
	.ram_we (ram_we),
	.ram_addr (ram_addr),
	.ram_wstrb (ram_wstrb),
	.ram_wdata (ram_wdata),
	.ram_rdata (ram_rdata),
	.dividend_wr (dividend_wr),
	.divisor_wr (divisor_wr),
	.wdata (wdata),
	.div_busy (div_busy),
	.dividend (dividend),
	.quotient (quotient),
	.remainder (remainder),
	.flags_wr (flags_wr),
	.flags_wdata (flags_wdata),
	.flags_rd (flags_rd)
);

dsp_local_ram dsp_local_ram_i
(
	.sys_clk (sys_clk),
	.ram_we (ram_we),
	.ram_addr (ram_addr),
	.ram_wstrb (ram_wstrb),
	.ram_wdata (ram_wdata),
	.ram_rdata (ram_rdata)
);

dsp_divider dsp_divider_i
(
	.sys_clk (sys_clk),
	.rst (rst),
	.dividend_wr (dividend_wr),
	.divisor_wr (divisor_wr),
	.wdata (wdata),
	.div_busy (div_busy),
	.dividend (dividend),
	.quotient (quotient),
	.remainder (remainder)
);

dsp_irq_flags dsp_irq_flags_i
(
	.sys_clk (sys_clk),
	.rst (rst),
	.ext_int_n (ext_int_n),
	.flags_wr (flags_wr),
	.flags_wdata (flags_wdata),
	.div_busy (div_busy), // Shown in the flags read word
	.flags_rd (flags_rd),
	.cpu_int (cpu_int)
);

endmodule

// File: dsp_top_sva.sv
`timescale 1ns/10ps
`include "dsp_params.svh"

module dsp_top_sva
(
	input logic sys_clk,
	input logic rst,
	input logic s_axi_awready,
	input logic s_axi_wready,
	input logic [1:0] s_axi_bresp,
	input logic s_axi_bvalid,
	input logic s_axi_bready,
	input logic [`DSP_DATA_W-1:0] s_axi_rdata,
	input logic [1:0] s_axi_rresp,
	input logic s_axi_rvalid,
	input logic s_axi_rready,
	input logic cpu_int
);

// Write response parked until the host takes it
property b_hold;
	@(posedge sys_clk) disable iff (rst)
	s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp);
endproperty

// Read data and response frozen while stalled
property r_hold;
	@(posedge sys_clk) disable iff (rst)
	s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata)
		&& $stable(s_axi_rresp);
endproperty

assert property (b_hold) else $error("Write response dropped or changed before bready");
assert property (r_hold) else $error("Read response dropped or changed before rready");
assert property (@(posedge sys_clk) s_axi_awready == s_axi_wready)
	else $error("awready and wready differ"); // Paired address and data accept

// Interrupt output held low by reset
assert property (@(posedge sys_clk) rst |=> !cpu_int)
	else $error("cpu_int high during reset");

endmodule

// File: tb_dsp_top.sv
`timescale 1ns/10ps
`include "dsp_params.svh"

module tb_dsp_top;

localparam int clk_period = 4;
localparam int ram_writes = 200;
localparam int div_pairs = 24;
localparam int bp_rounds = 30;
localparam int num_ops = 2 * ram_writes + 5 * div_pairs + 2 * bp_rounds + 60; // Misc tests too
localparam logic [1:0] okay = 2'b00;
localparam logic [1:0] slverr = 2'b10;

logic sys_clk;
logic rst;
logic [`DSP_IRQ_N-1:0] ext_int_n;
logic [`DSP_ADDR_W-1:0] s_axi_awaddr;
logic s_axi_awvalid;
logic s_axi_awready;
logic [`DSP_DATA_W-1:0] s_axi_wdata;
logic [`DSP_STRB_W-1:0] s_axi_wstrb;
logic s_axi_wvalid;
logic s_axi_wready;
logic [1:0] s_axi_bresp;
logic s_axi_bvalid;
logic s_axi_bready;
logic [`DSP_ADDR_W-1:0] s_axi_araddr;
logic s_axi_arvalid;
logic s_axi_arready;
logic [`DSP_DATA_W-1:0] s_axi_rdata;
logic [1:0] s_axi_rresp;
logic s_axi_rvalid;
logic s_axi_rready;
logic cpu_int;

// Shadow copy of the host-visible state
logic [`DSP_DATA_W-1:0] sh_ram [0:(1<<`DSP_RAM_AW)-1];
bit sh_known [0:(1<<`DSP_RAM_AW)-1]; // Word fully written once
logic [`DSP_IRQ_N-1:0] sh_mask;
logic [`DSP_IRQ_N-1:0] sh_latch;
logic sh_busy;
logic [`DSP_DATA_W-1:0] sh_dividend;
logic [`DSP_DATA_W-1:0] sh_div_a; // Operands captured by the divisor write
logic [`DSP_DATA_W-1:0] sh_div_b;

int bp_max; // Longest ready stall in cycles
int rd_latency; // Cycles from address accept to rvalid

// Results waiting for the compare process
string name_q[$];
logic [`DSP_DATA_W-1:0] exp_q[$];
logic [`DSP_DATA_W-1:0] act_q[$];
event result_ready;

dsp_top dsp_top_i (.*);

bind dsp_top dsp_top_sva dsp_top_sva_i (.*);

initial sys_clk = 1'b0;
always #(clk_period / 2) sys_clk = ~sys_clk;

task automatic next_cycle();
	@(posedge sys_clk);
	#1; // Drive point where DUT outputs have settled
endtask

task automatic compare(input string name, input logic [31:0] expected, input logic [31:0] actual);
	if (actual !== expected)
	begin
		$display("[ERROR] %s expected %h actual %h", name, expected, actual);
		$display("Testbench failed");
		$fatal(1, "Mismatch in %s", name);
	end
endtask

task automatic post_result(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	name_q.push_back(name);
	exp_q.push_back(expected);
	act_q.push_back(actual);
	-> result_ready;
endtask

// Compare process drains everything posted so far
always
begin
	@(result_ready);
	while (name_q.size() != 0)
		compare(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
end

function automatic logic [1:0] expected_bresp(input logic [15:0] addr);
	if (addr[15:12] == 4'h0 || addr == `DSP_FLAGS_ADDR || addr == `DSP_DIVIDEND_ADDR
		|| addr == `DSP_DIVISOR_ADDR)
		return okay;
	else
		return slverr; // Result registers and gaps
endfunction

// Reference for every readable address
function automatic void expected_read(input logic [15:0] addr, output logic [31:0] data,
	output logic [1:0] resp);
	data = '0;
	resp = okay;
	if (addr[15:12] == 4'h0)
		data = sh_ram[addr[11:2]];
	else if (addr == `DSP_FLAGS_ADDR)
		data = {27'd0, sh_busy, sh_latch, sh_mask};
	else if (addr == `DSP_DIVIDEND_ADDR)
		data = sh_dividend;
	else if (addr == `DSP_QUOTIENT_ADDR)
		data = (sh_div_b == 0) ? '1 : sh_div_a / sh_div_b; // Zero divisor gives all ones
	else if (addr == `DSP_REMAINDER_ADDR)
		data = (sh_div_b == 0) ? sh_div_a : sh_div_a % sh_div_b;
	else
		resp = slverr; // Divisor is write only and reads zero
endfunction

task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
	input logic [3:0] strb, output logic [1:0] resp);
	int stall;
	s_axi_awaddr = addr;
	s_axi_wdata = data;
	s_axi_wstrb = strb;
	s_axi_awvalid = 1'b1;
	s_axi_wvalid = 1'b1;
	while (!(s_axi_awready && s_axi_wready))
		next_cycle();
	next_cycle(); // Address and data taken here
	s_axi_awvalid = 1'b0;
	s_axi_wvalid = 1'b0;
	while (!s_axi_bvalid)
		next_cycle();
	stall = (bp_max > 0) ? int'($urandom % (bp_max + 1)) : 0;
	repeat (stall)
		next_cycle();
	resp = s_axi_bresp;
	s_axi_bready = 1'b1; // Only once bvalid is up
	next_cycle();
	s_axi_bready = 1'b0;
endtask

task automatic axi_read(input logic [15:0] addr, output logic [31:0] data,
	output logic [1:0] resp);
	int stall;
	s_axi_araddr = addr;
	s_axi_arvalid = 1'b1;
	while (!s_axi_arready)
		next_cycle();
	next_cycle();
	s_axi_arvalid = 1'b0;
	rd_latency = 0;
	while (!s_axi_rvalid)
	begin
		next_cycle();
		rd_latency++;
	end
	stall = (bp_max > 0) ? int'($urandom % (bp_max + 1)) : 0;
	repeat (stall)
		next_cycle();
	data = s_axi_rdata;
	resp = s_axi_rresp;
	s_axi_rready = 1'b1;
	next_cycle();
	s_axi_rready = 1'b0;
endtask

task automatic write_and_check(input string name, input logic [15:0] addr,
	input logic [31:0] data, input logic [3:0] strb);
	logic [1:0] resp;
	int idx;
	axi_write(addr, data, strb, resp);
	post_result({name, " bresp"}, 32'(expected_bresp(addr)), 32'(resp));
	idx = int'(addr[11:2]);
	if (addr[15:12] == 4'h0)
	begin
		for (int b = 0; b < 4; b++)
			if (strb[b])
				sh_ram[idx][b*8 +: 8] = data[b*8 +: 8]; // Byte merge
		sh_known[idx] = 1'b1;
	end
	else if (addr == `DSP_FLAGS_ADDR)
	begin
		sh_mask = data[1:0];
		sh_latch = sh_latch & ~data[3:2];
	end
	else if (addr == `DSP_DIVIDEND_ADDR)
		sh_dividend = data;
	else if (addr == `DSP_DIVISOR_ADDR)
	begin
		sh_div_a = sh_dividend;
		sh_div_b = data;
		sh_busy = 1'b1;
	end
endtask

task automatic read_and_check(input string name, input logic [15:0] addr);
	logic [31:0] data;
	logic [1:0] resp;
	logic [31:0] exp_data;
	logic [1:0] exp_resp;
	axi_read(addr, data, resp);
	if (addr == `DSP_QUOTIENT_ADDR || addr == `DSP_REMAINDER_ADDR)
		sh_busy = 1'b0; // Result comes back only once the divider is idle
	else
		post_result({name, " latency"}, 32'd0, 32'(rd_latency)); // rvalid right after accept
	expected_read(addr, exp_data, exp_resp);
	post_result({name, " rdata"}, exp_data, data);
	post_result({name, " rresp"}, 32'(exp_resp), 32'(resp));
endtask

task automatic run_division(input logic [31:0] a, input logic [31:0] b);
	write_and_check("dividend write", `DSP_DIVIDEND_ADDR, a, 4'hF);
	write_and_check("divisor write", `DSP_DIVISOR_ADDR, b, 4'hF);
	read_and_check("quotient", `DSP_QUOTIENT_ADDR);
	read_and_check("remainder", `DSP_REMAINDER_ADDR);
endtask

task automatic pulse_irq(input int line);
	ext_int_n[line] = 1'b0;
	repeat (4)
		next_cycle(); // Sync, edge and latch
	ext_int_n[line] = 1'b1;
	sh_latch[line] = 1'b1;
endtask

task automatic wait_cpu_int(input string name, input logic level);
	int cycles;
	cycles = 0;
	while (cpu_int !== level && cycles < 10)
	begin
		next_cycle();
		cycles++;
	end
	post_result(name, 32'(level), 32'(cpu_int));
endtask

// Watchdog allows 100 cycles per operation
initial
begin
	#(num_ops * 100 * clk_period);
	$display("Run timed out, %0d operations did not complete in time", num_ops);
	$display("Testbench failed");
	$fatal(1, "Timeout");
end

initial
begin
	int idx;
	int touched[$];
	logic [3:0] strb;
	logic [31:0] a;
	logic [31:0] b;
	void'($urandom(32559));
	rst = 1'b1;
	ext_int_n = '1; // Idle high
	s_axi_awaddr = '0;
	s_axi_awvalid = 1'b0;
	s_axi_wdata = '0;
	s_axi_wstrb = '0;
	s_axi_wvalid = 1'b0;
	s_axi_bready = 1'b0;
	s_axi_araddr = '0;
	s_axi_arvalid = 1'b0;
	s_axi_rready = 1'b0;
	bp_max = 0;
	sh_mask = '0;
	sh_latch = '0;
	sh_busy = 1'b0;
	sh_dividend = '0;
	sh_div_a = '0;
	sh_div_b = '0;
	for (int i = 0; i < (1 << `DSP_RAM_AW); i++)
		sh_known[i] = 1'b0;
	repeat (8)
		@(posedge sys_clk);
	#1;
	rst = 1'b0;
	next_cycle();

	// RAM test over 64 words spread across the window
	for (int n = 0; n < ram_writes; n++)
	begin
		idx = int'($urandom % 64) * 16 + 5;
		if (!sh_known[idx])
			touched.push_back(idx);
		strb = sh_known[idx] ? 4'($urandom) : 4'hF; // First write fills the word
		write_and_check("ram write", 16'(idx * 4), $urandom, strb);
	end
	foreach (touched[i])
		read_and_check("ram readback", 16'(touched[i] * 4));

	// Divider corner cases then random pairs
	run_division(32'h1234_5678, 32'd0);
	run_division(32'd7, 32'd1000);
	run_division(32'hFFFF_FFFF, 32'd1);
	for (int n = 0; n < div_pairs; n++)
	begin
		a = $urandom;
		b = $urandom >> ($urandom % 32); // Mix of divisor sizes
		run_division(a, b);
	end
	read_and_check("dividend readback", `DSP_DIVIDEND_ADDR);

	// Result read while the divider runs
	write_and_check("busy dividend", `DSP_DIVIDEND_ADDR, 32'hDEAD_BEEF, 4'hF);
	write_and_check("busy divisor", `DSP_DIVISOR_ADDR, 32'd12345, 4'hF);
	read_and_check("busy flags", `DSP_FLAGS_ADDR);
	read_and_check("busy quotient", `DSP_QUOTIENT_ADDR);
	post_result("busy read waited", 32'd1, 32'(rd_latency > 10));
	read_and_check("busy remainder", `DSP_REMAINDER_ADDR);

	// Interrupts
	write_and_check("mask irq0", `DSP_FLAGS_ADDR, 32'h1, 4'hF);
	pulse_irq(0);
	wait_cpu_int("cpu_int set", 1'b1);
	read_and_check("latch irq0", `DSP_FLAGS_ADDR);
	write_and_check("clear irq0", `DSP_FLAGS_ADDR, 32'h5, 4'hF);
	wait_cpu_int("cpu_int cleared", 1'b0);
	read_and_check("irq0 cleared", `DSP_FLAGS_ADDR);
	write_and_check("mask off", `DSP_FLAGS_ADDR, 32'h0, 4'hF);
	pulse_irq(1);
	repeat (10)
	begin
		next_cycle();
		post_result("cpu_int masked", 32'd0, 32'(cpu_int));
	end
	read_and_check("latch irq1 masked", `DSP_FLAGS_ADDR);
	write_and_check("clear irq1", `DSP_FLAGS_ADDR, 32'h8, 4'hF);
	read_and_check("irq1 cleared", `DSP_FLAGS_ADDR);

	// Error responses
	write_and_check("unmapped write", 16'h2000, 32'hA5A5_A5A5, 4'hF);
	write_and_check("quotient write", `DSP_QUOTIENT_ADDR, 32'h1, 4'hF);
	write_and_check("remainder write", `DSP_REMAINDER_ADDR, 32'h1, 4'hF);
	write_and_check("gap write", 16'h1001, 32'h3, 4'hF);
	read_and_check("unmapped read", 16'h2000);
	read_and_check("divisor read", `DSP_DIVISOR_ADDR);
	read_and_check("gap read", 16'h1014);

	// Back-pressure on both response channels
	bp_max = 8;
	for (int n = 0; n < bp_rounds; n++)
	begin
		idx = touched[$urandom % touched.size()];
		write_and_check("stalled write", 16'(idx * 4), $urandom, 4'($urandom));
		read_and_check("stalled read", 16'(idx * 4));
	end
	run_division($urandom, $urandom >> 16);
	bp_max = 0;

	next_cycle();
	compare("unchecked results", 32'd0, 32'(name_q.size()));
	$display("Testbench passed");
	$finish;
end

endmodule

// File: files.f
+incdir+.
dsp_pkg.sv
dsp_host_slave.sv
dsp_local_ram.sv
dsp_divider.sv
dsp_irq_flags.sv
dsp_top.sv
dsp_top_sva.sv
tb_dsp_top.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_dsp_top -f files.f -o sim_tb_dsp_top
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_tb_dsp_top
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit $status
fi

exit 0
